// File: Bender.yml
package:
  name: accel_spi

sources:
  - hw/accel_pkg.sv
  - hw/spi_byte_if.sv
  - hw/delay_timer.sv
  - hw/spi_byte_shifter.sv
  - hw/accel_seq_fsm.sv
  - hw/accel_sample_reg.sv
  - hw/accel_spi_top.sv
  - target: simulation
    files:
      - sim/accel_spi_assert.sv
      - sim/tb_accel_spi.sv

// File: hw/accel_pkg.sv
`default_nettype none

package accel_pkg;

    //////////////////////////////////////////////////
    // SPI framing
    localparam int SPI_BYTE_W = 8;                  // Bits per SPI byte
    localparam int SCLK_DIV   = 4;                  // iclk cycles per SCLK period
    localparam int PHASE_W    = $clog2(SCLK_DIV);
    localparam int BIT_CNT_W  = $clog2(SPI_BYTE_W);

    typedef logic [SPI_BYTE_W-1:0] spi_byte_t;

    //////////////////////////////////////////////////
    // Sensor timing, in iclk cycles at 4 MHz
    localparam int DELAY_W = 18;
    localparam logic [DELAY_W-1:0] POWER_UP_CYCLES = DELAY_W'(24000);   // 6 ms
    localparam logic [DELAY_W-1:0] SETTLE_CYCLES   = DELAY_W'(160000);  // 40 ms
    localparam logic [DELAY_W-1:0] READ_GAP_CYCLES = DELAY_W'(40000);   // 10 ms, 100 Hz

    //////////////////////////////////////////////////
    // Sensor commands and registers
    localparam spi_byte_t CMD_WRITE    = 8'h0A;
    localparam spi_byte_t CMD_READ     = 8'h0B;
    localparam spi_byte_t REG_MODE     = 8'h2D;
    localparam spi_byte_t MODE_MEASURE = 8'h02;
    localparam spi_byte_t REG_XDATA_L  = 8'h0E;     // Burst auto-increments from here

    // Frame layout
    localparam int DATA_BYTES = 6;                  // X lo/hi, Y lo/hi, Z lo/hi
    localparam int CMD_BYTES  = 2;                  // Instruction and address
    localparam int CFG_BYTES  = 3;
    localparam int READ_BYTES = CMD_BYTES + DATA_BYTES;
    localparam int BYTE_IDX_W = $clog2(READ_BYTES + 1);
    localparam int CAP_W      = $clog2(DATA_BYTES);

    // Packed sample, sign plus four bits per axis
    localparam int AXIS_MSB = 11;
    localparam int AXIS_LSB = 7;
    localparam int AXIS_W   = AXIS_MSB - AXIS_LSB + 1;
    localparam int SAMPLE_W = 3 * AXIS_W;

    typedef logic [SAMPLE_W-1:0] sample_t;

    typedef enum logic [2:0] {
        POWER_UP,
        CFG_WRITE,
        SETTLE,
        READ,
        READ_GAP
    } seq_state_t;

endpackage

`default_nettype wire

// File: hw/accel_sample_reg.sv
`timescale 1ns/10ps
`default_nettype none

module accel_sample_reg import accel_pkg::*; (
    input  wire          iclk,
    input  wire          arst_n,
    spi_byte_if.monitor  byte_if,
    input  logic         capture,
    output sample_t      acl_data,
    output logic         acl_valid
);

    logic [CAP_W-1:0]        cap_cnt;       // Even is a low byte, odd a high byte
    logic                    cap_en;
    spi_byte_t               lo_q;          // Low byte of the current axis
    logic [AXIS_W-1:0]       x_f;
    logic [AXIS_W-1:0]       y_f;
    logic [2*SPI_BYTE_W-1:0] axis_word;
    logic [AXIS_W-1:0]       axis_field;

    assign cap_en     = capture && byte_if.done;
    assign axis_word  = {byte_if.rx_byte, lo_q};
    assign axis_field = axis_word[AXIS_MSB:AXIS_LSB];   // Sign bit and top four

    //////////////////////////////////////////////////
    // Capture count and output word
    always_ff @(posedge iclk or negedge arst_n) begin
        if (!arst_n) begin
            cap_cnt   <= '0;
            acl_valid <= 1'b0;
            acl_data  <= '0;
        end else begin
            acl_valid <= 1'b0;
            if (cap_en) begin
                if (cap_cnt == CAP_W'(DATA_BYTES - 1)) begin
                    cap_cnt   <= '0;
                    acl_data  <= {x_f, y_f, axis_field};     // Z high byte completes it
                    acl_valid <= 1'b1;
                end else begin
                    cap_cnt <= cap_cnt + 1'b1;
                end
            end
        end
    end

    // Per-axis fields
    always_ff @(posedge iclk) begin
        if (cap_en) begin
            if (!cap_cnt[0]) begin
                lo_q <= byte_if.rx_byte;
            end else if (cap_cnt[CAP_W-1:1] == '0) begin
                x_f <= axis_field;
            end else if (cap_cnt[CAP_W-1:1] == (CAP_W-1)'(1)) begin
                y_f <= axis_field;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/accel_seq_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module accel_seq_fsm import accel_pkg::*; (
    input  wire                iclk,
    input  wire                arst_n,
    spi_byte_if.master         byte_if,
    output logic               cs,
    output logic               load,
    output logic [DELAY_W-1:0] load_value,
    input  logic               expired,
    output logic               capture
);

    seq_state_t            state;
    logic                  armed;       // Timer loaded for the current wait
    logic                  lead;        // First frame cycle, cs low but no SCLK yet
    logic [BYTE_IDX_W-1:0] byte_idx;    // Bytes started in this frame
    logic [BYTE_IDX_W-1:0] frame_len;
    logic                  in_wait;
    logic                  in_frame;
    logic                  frame_end;

    assign in_wait   = (state == POWER_UP) || (state == SETTLE) || (state == READ_GAP);
    assign in_frame  = !in_wait;
    assign frame_len = (state == READ) ? BYTE_IDX_W'(READ_BYTES) : BYTE_IDX_W'(CFG_BYTES);
    assign frame_end = in_frame && byte_if.done && (byte_idx == frame_len);

    //////////////////////////////////////////////////
    // Timer control
    assign load = in_wait && !armed;            // Once, on entry to each wait

    always_comb begin
        case (state)
            POWER_UP: load_value = POWER_UP_CYCLES;
            SETTLE:   load_value = SETTLE_CYCLES;
            default:  load_value = READ_GAP_CYCLES;
        endcase
    end

    //////////////////////////////////////////////////
    // Byte requests
    //
    // First byte goes out after the lead cycle, the rest chain on done.
    assign byte_if.start = in_frame && !lead &&
                           ((byte_idx == '0) || (byte_if.done && (byte_idx != frame_len)));

    always_comb begin
        byte_if.tx_byte = '0;                   // Dummy byte while reading data
        if (state == CFG_WRITE) begin
            case (byte_idx)
                BYTE_IDX_W'(0): byte_if.tx_byte = CMD_WRITE;
                BYTE_IDX_W'(1): byte_if.tx_byte = REG_MODE;
                default:        byte_if.tx_byte = MODE_MEASURE;
            endcase
        end else if (state == READ) begin
            case (byte_idx)
                BYTE_IDX_W'(0): byte_if.tx_byte = CMD_READ;
                BYTE_IDX_W'(1): byte_if.tx_byte = REG_XDATA_L;
                default:        byte_if.tx_byte = '0;
            endcase
        end
    end

    // Done of byte k arrives with byte_idx = k + 1
    assign capture = (state == READ) && byte_if.done && (byte_idx > BYTE_IDX_W'(CMD_BYTES));

    //////////////////////////////////////////////////
    // Sequence
    always_ff @(posedge iclk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= POWER_UP;
            armed    <= 1'b0;
            lead     <= 1'b0;
            byte_idx <= '0;
            cs       <= 1'b1;
        end else begin
            lead <= 1'b0;
            if (byte_if.start) begin
                byte_idx <= byte_idx + 1'b1;
            end

            case (state)
                POWER_UP, SETTLE, READ_GAP: begin
                    if (!armed) begin
                        armed <= 1'b1;
                    end else if (expired) begin
                        armed    <= 1'b0;
                        lead     <= 1'b1;
                        byte_idx <= '0;
                        cs       <= 1'b0;           // One cycle ahead of SCLK
                        if (state == POWER_UP) begin
                            state <= CFG_WRITE;
                        end else begin
                            state <= READ;
                        end
                    end
                end
                CFG_WRITE: begin
                    if (frame_end) begin
                        cs    <= 1'b1;
                        state <= SETTLE;
                    end
                end
                default: begin                      // READ
                    if (frame_end) begin
                        cs    <= 1'b1;
                        state <= READ_GAP;          // Loops forever
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/accel_spi_top.sv
`timescale 1ns/10ps
`default_nettype none

module accel_spi_top import accel_pkg::*; (
    input  wire                 iclk,
    input  wire                 arst_n,
    input  wire                 miso,
    output logic                sclk,
    output logic                mosi,
    output logic                cs,
    output logic [SAMPLE_W-1:0] acl_data,
    output logic                acl_valid
);

    logic               load;
    logic [DELAY_W-1:0] load_value;
    logic               expired;
    logic               capture;

    spi_byte_if byte_bus ();            // Sequencer to shifter, watched by sample reg

    //////////////////////////////////////////////////
    // Wait timing
    delay_timer u_delay_timer (
        .iclk       (iclk),
        .arst_n     (arst_n),
        .load       (load),
        .load_value (load_value),
        .expired    (expired)
    );

    //////////////////////////////////////////////////
    // SPI pins
    spi_byte_shifter u_shifter (
        .iclk    (iclk),
        .arst_n  (arst_n),
        .cs      (cs),
        .byte_if (byte_bus),
        .sclk    (sclk),
        .mosi    (mosi),
        .miso    (miso)
    );

    accel_seq_fsm u_seq_fsm (
        .iclk       (iclk),
        .arst_n     (arst_n),
        .byte_if    (byte_bus),
        .cs         (cs),
        .load       (load),
        .load_value (load_value),
        .expired    (expired),
        .capture    (capture)
    );

    // Output word
    accel_sample_reg u_sample_reg (
        .iclk      (iclk),
        .arst_n    (arst_n),
        .byte_if   (byte_bus),
        .capture   (capture),
        .acl_data  (acl_data),
        .acl_valid (acl_valid)
    );

endmodule

`default_nettype wire

// File: hw/delay_timer.sv
`timescale 1ns/10ps
`default_nettype none

module delay_timer import accel_pkg::*; (
    input  wire                iclk,
    input  wire                arst_n,
    input  logic               load,
    input  logic [DELAY_W-1:0] load_value,
    output logic               expired
);

    logic [DELAY_W-1:0] count;

    //////////////////////////////////////////////////
    // Down-counter
    //
    // The load cycle itself counts as the first cycle, so the stored value
    // is one less than requested. That puts expired exactly load_value
    // cycles after the load pulse.
    always_ff @(posedge iclk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;                            // Idle timer reads as expired
        end else if (load) begin
            count <= load_value - 1'b1;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Stays high until the next load
    assign expired = (count == '0);

endmodule

`default_nettype wire

// File: hw/spi_byte_if.sv
`timescale 1ns/10ps
`default_nettype none

// One byte transfer between sequencer and shifter
interface spi_byte_if import accel_pkg::*; ();

    logic      start;       // Pulse, only when idle or with done
    spi_byte_t tx_byte;
    spi_byte_t rx_byte;     // Valid with done, held until next done
    logic      done;        // Pulse

    modport master (
        output start,
        output tx_byte,
        input  rx_byte,
        input  done
    );

    modport shifter (
        input  start,
        input  tx_byte,
        output rx_byte,
        output done
    );

    modport monitor (
        input  rx_byte,
        input  done
    );

endinterface

`default_nettype wire

// File: hw/spi_byte_shifter.sv
`timescale 1ns/10ps
`default_nettype none

module spi_byte_shifter import accel_pkg::*; (
    input  wire          iclk,
    input  wire          arst_n,
    input  logic         cs,
    spi_byte_if.shifter  byte_if,
    output logic         sclk,
    output logic         mosi,
    input  wire          miso
);

    logic [PHASE_W-1:0]   phase;        // Position inside the current bit
    logic [BIT_CNT_W-1:0] bit_cnt;      // Bits left, MSB first
    logic                 active;
    spi_byte_t            shreg;
    logic                 last_phase;
    logic                 sample_phase;

    assign last_phase   = (phase == PHASE_W'(SCLK_DIV - 1));
    assign sample_phase = (phase == PHASE_W'(SCLK_DIV / 2 - 1));    // Edge where SCLK rises

    // Mode 0: low for the first half of each bit, high for the second
    assign sclk = active && !cs && (phase >= PHASE_W'(SCLK_DIV / 2));

    //////////////////////////////////////////////////
    // Bit timing and MOSI
    //
    // The start cycle acts as phase 0 of bit 7. With start arriving in the
    // done cycle of the previous byte this keeps SCLK running without a gap.
    always_ff @(posedge iclk or negedge arst_n) begin
        if (!arst_n) begin
            active       <= 1'b0;
            phase        <= '0;
            bit_cnt      <= '0;
            mosi         <= 1'b0;
            byte_if.done <= 1'b0;
        end else begin
            byte_if.done <= 1'b0;
            if (byte_if.start) begin
                active  <= 1'b1;
                phase   <= PHASE_W'(1);
                bit_cnt <= BIT_CNT_W'(SPI_BYTE_W - 1);
                mosi    <= byte_if.tx_byte[SPI_BYTE_W-1];
            end else if (active) begin
                phase <= last_phase ? '0 : phase + 1'b1;
                if (last_phase) begin
                    if (bit_cnt == '0) begin
                        active       <= 1'b0;
                        byte_if.done <= 1'b1;               // MOSI keeps the last bit
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                        mosi    <= shreg[SPI_BYTE_W-1];     // Next bit, already shifted up
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Shift register, MISO enters at the LSB
    always_ff @(posedge iclk) begin
        if (byte_if.start) begin
            shreg <= byte_if.tx_byte;
        end else if (active && sample_phase) begin
            shreg <= {shreg[SPI_BYTE_W-2:0], miso};
        end

        if (active && last_phase && (bit_cnt == '0)) begin
            byte_if.rx_byte <= shreg;                       // All eight bits are in by now
        end
    end

endmodule

`default_nettype wire

// File: sim.f
hw/accel_pkg.sv
hw/spi_byte_if.sv
hw/delay_timer.sv
hw/spi_byte_shifter.sv
hw/accel_seq_fsm.sv
hw/accel_sample_reg.sv
hw/accel_spi_top.sv
sim/accel_spi_assert.sv
sim/tb_accel_spi.sv

// File: sim/accel_spi_assert.sv
`timescale 1ns/10ps
`default_nettype none

module accel_spi_assert (
    input wire iclk,
    input wire arst_n,
    input wire cs,
    input wire sclk,
    input wire mosi,
    input wire acl_valid
);

    //////////////////////////////////////////////////
    // SPI pins
    property p_sclk_idle_low;                       // Mode 0 idles low, also across the cs edge
        @(posedge iclk) disable iff (!arst_n)
            cs |-> !sclk && !$past(sclk);
    endproperty

    // Sensor samples on the rising edge, so no change in the high half
    property p_mosi_stable_high;
        @(posedge iclk) disable iff (!arst_n)
            sclk |-> $stable(mosi);
    endproperty

    property p_valid_single;                        // One-cycle strobe
        @(posedge iclk) disable iff (!arst_n)
            acl_valid |=> !acl_valid;
    endproperty

    a_sclk_idle_low: assert property (p_sclk_idle_low)
        else $error("sclk high while cs is deasserted");
    a_mosi_stable_high: assert property (p_mosi_stable_high)
        else $error("mosi changed while sclk was high");
    a_valid_single: assert property (p_valid_single)
        else $error("acl_valid high for two cycles in a row");

endmodule

bind accel_spi_top accel_spi_assert u_spi_assert (
    .iclk      (iclk),
    .arst_n    (arst_n),
    .cs        (cs),
    .sclk      (sclk),
    .mosi      (mosi),
    .acl_valid (acl_valid)
);

`default_nettype wire

// File: sim/tb_accel_spi.sv
`timescale 1ns/10ps
`default_nettype none

module tb_accel_spi import accel_pkg::*; ();

    localparam int CLK_HALF      = 50;                          // 100 ns period
    localparam int RESET_CYCLES  = 10;
    localparam int SEED          = 73;
    localparam int NUM_SAMPLES   = 5;
    localparam int CFG_EDGES     = 3 * 8;                       // Three bytes
    localparam int READ_EDGES    = 8 * 8;                       // Command, address, six data
    localparam int DATA_BITS     = 6 * 8;
    localparam int VALID_TIMEOUT = 2 * (int'(POWER_UP_CYCLES) + int'(SETTLE_CYCLES));

    logic            iclk;
    logic            arst_n;
    logic            miso;
    logic            sclk;
    logic            mosi;
    logic            cs;
    sample_t         acl_data;
    logic            acl_valid;

    // Sensor model
    logic            cs_q;
    logic            sclk_q;
    spi_byte_t       rx_sh;
    int              rx_bits;
    int              sclk_edges;
    logic [47:0]     tx_sh;                                     // X lo first, Z hi last
    int              tx_bits;
    spi_byte_t       frame_bytes[$];
    logic [15:0]     axis_regs[$];                              // X, Y, Z per read frame

    // Bookkeeping
    int              cyc;
    int              cs_rise_cyc;
    int              frames_done;
    int              reads_done;
    int              valid_cnt;
    sample_t         held_data;
    sample_t         exp_q[$];

    accel_spi_top dut_i (
        .iclk      (iclk),
        .arst_n    (arst_n),
        .miso      (miso),
        .sclk      (sclk),
        .mosi      (mosi),
        .cs        (cs),
        .acl_data  (acl_data),
        .acl_valid (acl_valid)
    );

    //////////////////////////////////////////////////
    // Error handling
    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    // Reference packing, bits 11 to 7 of each axis, X on top
    function automatic sample_t pack_sample(input logic [15:0] x, input logic [15:0] y,
                                            input logic [15:0] z);
        return {x[11:7], y[11:7], z[11:7]};
    endfunction

    function automatic int min_gap(input int frame);
        if (frame == 0) return int'(POWER_UP_CYCLES);
        if (frame == 1) return int'(SETTLE_CYCLES);
        return int'(READ_GAP_CYCLES);
    endfunction

    // New axis registers for each read frame
    task automatic load_axes();
        logic [15:0] ax;
        logic [15:0] ay;
        logic [15:0] az;
        if (axis_regs.size() < 3) begin
            $display("No random axis values left for read frame %0d", frames_done);
            abort_run();
        end
        ax      = axis_regs.pop_front();
        ay      = axis_regs.pop_front();
        az      = axis_regs.pop_front();
        tx_sh   = {ax[7:0], ax[15:8], ay[7:0], ay[15:8], az[7:0], az[15:8]};
        tx_bits = DATA_BITS;
        exp_q.push_back(pack_sample(ax, ay, az));
    endtask

    task automatic check_frame();
        if (frames_done == 0) begin
            check_equal(sclk_edges, CFG_EDGES, "SCLK rising edges in config frame");
            check_equal(frame_bytes.size(), 3, "bytes in config frame");
            check_equal(frame_bytes[0], 8'h0A, "config byte 0");
            check_equal(frame_bytes[1], 8'h2D, "config byte 1");
            check_equal(frame_bytes[2], 8'h02, "config byte 2");
        end else begin
            check_equal(sclk_edges, READ_EDGES, $sformatf("SCLK edges in frame %0d", frames_done));
            check_equal(frame_bytes.size(), 8, "bytes in read frame");
            check_equal(frame_bytes[0], 8'h0B, "read instruction");
            check_equal(frame_bytes[1], 8'h0E, "read start address");
        end
    endtask

    task automatic wait_for_valid(input int limit);
        int n;
        n = 0;
        do begin
            @(posedge iclk);
            n++;
        end while (!acl_valid && (n < limit));
        if (!acl_valid) begin
            $display("Timed out after %0d cycles waiting for acl_valid", limit);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////
    // Clock
    initial begin
        iclk = 1'b0;
        forever #(CLK_HALF) iclk = ~iclk;
    end

    //////////////////////////////////////////////////
    // Sensor model and pin checks, pre-edge values seen at each iclk edge
    always @(posedge iclk) begin
        if (arst_n) begin
            cyc++;
            if (acl_valid) begin
                valid_cnt++;
                held_data = acl_data;
            end else begin
                check_equal(acl_data, held_data, "acl_data changed between valid pulses");
            end

            if (!cs && cs_q) begin                              // Frame start
                check_equal((cyc - cs_rise_cyc) >= min_gap(frames_done), 1'b1,
                            $sformatf("cs high %0d cycles before frame %0d",
                                      cyc - cs_rise_cyc, frames_done));
                check_equal(valid_cnt, reads_done, "acl_valid pulses per read frame");
                frame_bytes.delete();
                sclk_edges = 0;
                rx_bits    = 0;
                tx_bits    = 0;
            end

            if (!cs && sclk && !sclk_q) begin                   // SCLK rose, take MOSI
                rx_sh = {rx_sh[6:0], mosi};
                rx_bits++;
                sclk_edges++;
                if (rx_bits == 8) begin
                    frame_bytes.push_back(rx_sh);
                    rx_bits = 0;
                    if ((frames_done > 0) && (frame_bytes.size() == 2)) begin
                        load_axes();
                    end
                end
            end

            if (!cs && !sclk && sclk_q) begin                   // SCLK fell, next data bit
                if (tx_bits > 0) begin
                    miso <= tx_sh[47];
                    tx_sh = tx_sh << 1;
                    tx_bits--;
                end else begin
                    miso <= 1'b0;
                end
            end

            if (cs && !cs_q) begin                              // Frame end
                check_frame();
                if (frames_done > 0) begin
                    reads_done++;
                end
                frames_done++;
                cs_rise_cyc = cyc;
            end

            cs_q   = cs;
            sclk_q = sclk;
        end
    end

    //////////////////////////////////////////////////
    // Main sequence
    initial begin
        sample_t exp_word;
        void'($urandom(SEED));
        for (int i = 0; i < 3 * (NUM_SAMPLES + 1); i++) begin
            axis_regs.push_back(16'($urandom()));
        end
        arst_n      = 1'b0;
        miso        = 1'b0;
        cs_q        = 1'b1;
        sclk_q      = 1'b0;
        cyc         = 0;
        cs_rise_cyc = 0;
        frames_done = 0;
        reads_done  = 0;
        valid_cnt   = 0;
        held_data   = '0;
        tx_bits     = 0;
        repeat (RESET_CYCLES) @(posedge iclk);
        arst_n <= 1'b1;
        @(posedge iclk);

        check_equal(cs, 1'b1, "cs after reset");
        check_equal(sclk, 1'b0, "sclk after reset");
        check_equal(mosi, 1'b0, "mosi after reset");
        check_equal(acl_valid, 1'b0, "acl_valid after reset");
        check_equal(acl_data, '0, "acl_data after reset");

        for (int i = 0; i < NUM_SAMPLES; i++) begin
            wait_for_valid(VALID_TIMEOUT);
            if (exp_q.size() == 0) begin
                $display("acl_valid pulsed with no read frame data pending");
                abort_run();
            end
            exp_word = exp_q.pop_front();
            check_equal(acl_data, exp_word, $sformatf("acl_data of sample %0d", i));
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
